/* hdl/exec_pkg.sv */
// shared constants for the execute stage; mode and sub-op codes must match the decode stage
package exec_pkg;

	// widths
	localparam int XLEN    = 32;
	localparam int MODE_W  = 5;
	localparam int SUB_W   = 2;
	localparam int DEST_W  = 4;
	localparam int FDEST_W = 2;
	localparam int EXC_W   = 8;

	// main modes
	localparam logic [MODE_W-1:0] MODE_UARITH = 5'd1;
	localparam logic [MODE_W-1:0] MODE_SARITH = 5'd2;
	localparam logic [MODE_W-1:0] MODE_SHIFT  = 5'd5;
	localparam logic [MODE_W-1:0] MODE_LOGIC  = 5'd6;
	localparam logic [MODE_W-1:0] MODE_MOVE   = 5'd9;
	localparam logic [MODE_W-1:0] MODE_CMP    = 5'd17;
	localparam logic [MODE_W-1:0] MODE_SEXT   = 5'd18;

	// arithmetic sub-ops
	localparam logic [SUB_W-1:0] ARITH_ADD = 2'd0;
	localparam logic [SUB_W-1:0] ARITH_SUB = 2'd1;
	localparam logic [SUB_W-1:0] ARITH_MUL = 2'd2;
	localparam logic [SUB_W-1:0] ARITH_DIV = 2'd3;

	// shift sub-ops
	localparam logic [SUB_W-1:0] SH_LEFT   = 2'd0;
	localparam logic [SUB_W-1:0] SH_RIGHT  = 2'd1;
	localparam logic [SUB_W-1:0] ROT_LEFT  = 2'd2;
	localparam logic [SUB_W-1:0] ROT_RIGHT = 2'd3;

	// logic sub-ops
	localparam logic [SUB_W-1:0] LG_AND = 2'd0;
	localparam logic [SUB_W-1:0] LG_OR  = 2'd1;
	localparam logic [SUB_W-1:0] LG_NOT = 2'd2;
	localparam logic [SUB_W-1:0] LG_XOR = 2'd3;

	// compare and sign-extend sub-ops
	localparam logic [SUB_W-1:0] CMP_UNSIGNED = 2'd0;
	localparam logic [SUB_W-1:0] CMP_SIGNED   = 2'd1;
	localparam logic [SUB_W-1:0] SEXT_BYTE    = 2'd0;
	localparam logic [SUB_W-1:0] SEXT_HALF    = 2'd1;

	localparam int unsigned SHIFT_MAX = 32; // largest legal shift amount
	localparam int MUL_BITS_PER_STEP  = 4;  // partial products per multiplier cycle

	// exception codes
	localparam logic [EXC_W-1:0] EXC_DIV_ZERO = 8'd5;
	localparam logic [EXC_W-1:0] EXC_SHIFT_L  = 8'd6;
	localparam logic [EXC_W-1:0] EXC_SHIFT_R  = 8'd7;

	// multiply and divide share one 64-bit result word
	typedef union packed {
		logic [2*XLEN-1:0] product;
		struct packed {
			logic [XLEN-1:0] remainder; // high word
			logic [XLEN-1:0] quotient;  // low word
		} division;
	} wide_result_u;

endpackage

/* hdl/int_mul.sv */
// product and done are valid in the last step cycle only; start must not arrive while busy
module int_mul import exec_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              signed_op,
	input  logic [XLEN-1:0]   x1,
	input  logic [XLEN-1:0]   x2,
	output logic              done,
	output logic [2*XLEN-1:0] product
);

	logic busy, wide, last_step;
	logic [3:0] step;
	logic [2*XLEN-1:0] ma, mb, acc, acc_next;

	// signed needs all 64 multiplier bits, unsigned only the low 32
	assign last_step = busy && (step == (wide ? 4'(2*XLEN/MUL_BITS_PER_STEP - 1)
		: 4'(XLEN/MUL_BITS_PER_STEP - 1)));

	always_comb begin
		acc_next = acc;
		for (int j = 0; j < MUL_BITS_PER_STEP; j++) begin
			if (mb[j])
				acc_next = acc_next + (ma << j);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			step <= '0;
		end else if (start) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			step <= step + 4'd1;
			if (last_step)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			ma   <= signed_op ? {{XLEN{x1[XLEN-1]}}, x1} : {{XLEN{1'b0}}, x1};
			mb   <= signed_op ? {{XLEN{x2[XLEN-1]}}, x2} : {{XLEN{1'b0}}, x2};
			acc  <= '0;
			wide <= signed_op;
		end else if (busy) begin
			acc <= acc_next;
			ma  <= ma << MUL_BITS_PER_STEP; // next group of weights
			mb  <= mb >> MUL_BITS_PER_STEP;
		end
	end

	assign done    = last_step;
	assign product = acc_next;

	a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

/* hdl/int_div.sv */
// divisor must be nonzero; quotient and remainder are valid only while done is high
module int_div import exec_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  logic            signed_op,
	input  logic [XLEN-1:0] x1,
	input  logic [XLEN-1:0] x2,
	output logic            done,
	output logic [XLEN-1:0] quotient,
	output logic [XLEN-1:0] remainder
);

	logic busy, neg_q, neg_r, iterate;
	logic [5:0] step;
	logic [XLEN-1:0] mag1, mag2, quo, rem, dvs;
	logic [XLEN:0] shifted, trial;

	// magnitudes; 0x80000000 stays correct as an unsigned value
	assign mag1 = (signed_op && x1[XLEN-1]) ? -x1 : x1;
	assign mag2 = (signed_op && x2[XLEN-1]) ? -x2 : x2;

	assign iterate = busy && (step != 6'(XLEN));
	assign shifted = {rem, quo[XLEN-1]};
	assign trial   = shifted - {1'b0, dvs};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			step <= '0;
		end else if (start) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			step <= step + 6'd1;
			if (step == 6'(XLEN))
				busy <= 1'b0; // sign fix-up cycle done
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			quo   <= mag1;
			rem   <= '0;
			dvs   <= mag2;
			neg_q <= signed_op && (x1[XLEN-1] ^ x2[XLEN-1]);
			neg_r <= signed_op && x1[XLEN-1];
		end else if (iterate) begin
			if (!trial[XLEN]) begin
				rem <= trial[XLEN-1:0];
				quo <= {quo[XLEN-2:0], 1'b1};
			end else begin
				rem <= shifted[XLEN-1:0]; // restore
				quo <= {quo[XLEN-2:0], 1'b0};
			end
		end
	end

	assign done      = busy && (step == 6'(XLEN));
	assign quotient  = neg_q ? -quo : quo;
	assign remainder = neg_r ? -rem : rem; // follows the dividend sign

endmodule

/* hdl/int_arith.sv */
// caller must hold sub_op and operands stable from start until done
module int_arith import exec_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  logic             signed_op,
	input  logic [SUB_W-1:0] sub_op,
	input  logic [XLEN-1:0]  x1,
	input  logic [XLEN-1:0]  x2,
	output logic             done,
	output wide_result_u     result
);

	logic [2*XLEN-1:0] a_ext, b_ext, sum_r, product;
	logic [XLEN-1:0] quotient, remainder;
	logic as_start, as_done, mul_start, mul_done, div_start, div_done;

	assign a_ext = signed_op ? {{XLEN{x1[XLEN-1]}}, x1} : {{XLEN{1'b0}}, x1};
	assign b_ext = signed_op ? {{XLEN{x2[XLEN-1]}}, x2} : {{XLEN{1'b0}}, x2};

	assign as_start  = start && ((sub_op == ARITH_ADD) || (sub_op == ARITH_SUB));
	assign mul_start = start && (sub_op == ARITH_MUL);
	assign div_start = start && (sub_op == ARITH_DIV);

	always_ff @(posedge clk) begin
		if (rst)
			as_done <= 1'b0;
		else
			as_done <= as_start;
	end

	always_ff @(posedge clk) begin
		if (as_start)
			sum_r <= (sub_op == ARITH_SUB) ? a_ext - b_ext : a_ext + b_ext; // 64-bit wide
	end

	int_mul u_mul (
		.clk       (clk),
		.rst       (rst),
		.start     (mul_start),
		.signed_op (signed_op),
		.x1        (x1),
		.x2        (x2),
		.done      (mul_done),
		.product   (product)
	);

	int_div u_div (
		.clk       (clk),
		.rst       (rst),
		.start     (div_start),
		.signed_op (signed_op),
		.x1        (x1),
		.x2        (x2),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	assign done = as_done || mul_done || div_done;

	always_comb begin
		result = '0;
		case (sub_op)
			ARITH_MUL: result.product = product;
			ARITH_DIV: begin
				result.division.quotient  = quotient;
				result.division.remainder = remainder;
			end
			default:   result.product = sum_r;
		endcase
	end

endmodule

/* hdl/exec_simple.sv */
// purely combinational; shift results are only meaningful for amounts up to 32
module exec_simple import exec_pkg::*; (
	input  logic [MODE_W-1:0] mode,
	input  logic [SUB_W-1:0]  sub_op,
	input  logic [XLEN-1:0]   x1,
	input  logic [XLEN-1:0]   x2,
	output logic [XLEN-1:0]   y_lo,
	output logic [XLEN-1:0]   y_hi
);

	logic [5:0] amt, amt_inv;
	logic [2*XLEN-1:0] wide_left;
	logic [XLEN-1:0] right_part, spill;
	logic nz1, nz2, lt;

	assign amt        = x2[5:0];          // upper bits only matter for the trap
	assign amt_inv    = 6'd32 - amt;
	assign wide_left  = {{XLEN{1'b0}}, x1} << amt;
	assign right_part = x1 >> amt;
	assign spill      = x1 << amt_inv;    // bits pushed out the bottom
	assign nz1        = (x1 != '0);
	assign nz2        = (x2 != '0);

	always_comb begin
		case (sub_op)
			CMP_UNSIGNED: lt = (x1 < x2);
			CMP_SIGNED:   lt = ($signed(x1) < $signed(x2));
			default:      lt = 1'b0;
		endcase
	end

	always_comb begin
		y_lo = '0;
		y_hi = '0;
		case (mode)
			MODE_SHIFT: begin
				case (sub_op)
					SH_LEFT: begin
						y_lo = wide_left[XLEN-1:0];
						y_hi = wide_left[2*XLEN-1:XLEN];
					end
					SH_RIGHT: begin
						y_lo = right_part;
						y_hi = spill;
					end
					ROT_LEFT: begin
						y_lo = wide_left[XLEN-1:0] | wide_left[2*XLEN-1:XLEN];
						y_hi = wide_left[2*XLEN-1:XLEN]; // bits rotated past the top
					end
					ROT_RIGHT: begin
						y_lo = right_part | spill;
						y_hi = spill;
					end
				endcase
			end
			MODE_LOGIC: begin
				case (sub_op)
					LG_AND: begin
						y_lo    = x1 & x2;
						y_hi[0] = nz1 && nz2;
					end
					LG_OR: begin
						y_lo    = x1 | x2;
						y_hi[0] = nz1 || nz2;
					end
					LG_NOT: begin
						y_lo    = ~x2;
						y_hi[0] = !nz2;
					end
					LG_XOR: begin
						y_lo    = x1 ^ x2;
						y_hi[0] = nz1 ^ nz2;
					end
				endcase
			end
			MODE_CMP: begin
				y_hi[0] = (x1 == x2);
				y_hi[1] = lt;
			end
			MODE_MOVE: begin
				y_lo = x2;
			end
			MODE_SEXT: begin
				case (sub_op)
					SEXT_BYTE: y_lo = {{(XLEN-8){x2[7]}}, x2[7:0]};
					SEXT_HALF: y_lo = {{(XLEN-16){x2[15]}}, x2[15:0]};
					default:   y_lo = '0;
				endcase
			end
			default: begin
				y_lo = '0; // arithmetic and unknown modes
				y_hi = '0;
			end
		endcase
	end

endmodule

/* hdl/exec_unit.sv */
// one operation in flight; inputs are taken only when idle and the result is held until out_ready
module exec_unit import exec_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	output logic               in_ready,
	input  logic [MODE_W-1:0]  mode,
	input  logic [SUB_W-1:0]   sub_op,
	input  logic [XLEN-1:0]    x1,
	input  logic [XLEN-1:0]    x2,
	input  logic [DEST_W-1:0]  dest_sel,
	input  logic [FDEST_W-1:0] flag_sel,
	output logic               out_valid,
	input  logic               out_ready,
	output logic [XLEN-1:0]    y_lo,
	output logic [XLEN-1:0]    y_hi,
	output logic [DEST_W-1:0]  dest,
	output logic [FDEST_W-1:0] flag_dest,
	output logic               exc,
	output logic [EXC_W-1:0]   exc_code
);

	logic busy, fresh, accept, finish;
	logic [MODE_W-1:0] op_mode;
	logic [SUB_W-1:0] op_sub;
	logic [XLEN-1:0] op_x1, op_x2;
	logic [DEST_W-1:0] op_dest;
	logic [FDEST_W-1:0] op_flag;
	logic is_arith, known, div_zero, shift_range, raise;
	logic arith_start, arith_done, arith_signed;
	logic [EXC_W-1:0] code;
	logic [XLEN-1:0] simple_lo, simple_hi, res_lo, res_hi;
	wide_result_u arith_res;

	assign in_ready = !busy && !out_valid;
	assign accept   = in_valid && in_ready;

	assign is_arith     = (op_mode == MODE_UARITH) || (op_mode == MODE_SARITH);
	assign arith_signed = (op_mode == MODE_SARITH);
	assign known = is_arith || (op_mode == MODE_SHIFT) || (op_mode == MODE_LOGIC) ||
		(op_mode == MODE_MOVE) || (op_mode == MODE_CMP) || (op_mode == MODE_SEXT);

	// traps, checked on the registered operation
	assign div_zero    = is_arith && (op_sub == ARITH_DIV) && (op_x2 == '0);
	assign shift_range = (op_mode == MODE_SHIFT) && (op_x2 > SHIFT_MAX);
	assign raise       = div_zero || shift_range;
	assign code = div_zero ? EXC_DIV_ZERO :
		((op_sub == SH_RIGHT) || (op_sub == ROT_RIGHT)) ? EXC_SHIFT_R : EXC_SHIFT_L;

	assign arith_start = fresh && is_arith && !raise; // one pulse per accepted op
	assign finish = busy && (arith_done || (fresh && !(is_arith && !raise)));

	assign res_lo = raise ? '0 : is_arith ? arith_res.product[XLEN-1:0] : simple_lo;
	assign res_hi = raise ? '0 : is_arith ? arith_res.product[2*XLEN-1:XLEN] : simple_hi;

	exec_simple u_simple (
		.mode   (op_mode),
		.sub_op (op_sub),
		.x1     (op_x1),
		.x2     (op_x2),
		.y_lo   (simple_lo),
		.y_hi   (simple_hi)
	);

	int_arith u_arith (
		.clk       (clk),
		.rst       (rst),
		.start     (arith_start),
		.signed_op (arith_signed),
		.sub_op    (op_sub),
		.x1        (op_x1),
		.x2        (op_x2),
		.done      (arith_done),
		.result    (arith_res)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			fresh     <= 1'b0;
			out_valid <= 1'b0;
			exc       <= 1'b0;
		end else begin
			fresh <= accept;
			if (accept)
				busy <= 1'b1;
			else if (finish)
				busy <= 1'b0;
			if (finish) begin
				out_valid <= 1'b1;
				exc       <= raise;
			end else if (out_valid && out_ready) begin
				out_valid <= 1'b0; // result consumed
			end
		end
	end

	// operation register, stable until the result is produced
	always_ff @(posedge clk) begin
		if (accept) begin
			op_mode <= mode;
			op_sub  <= sub_op;
			op_x1   <= x1;
			op_x2   <= x2;
			op_dest <= dest_sel;
			op_flag <= flag_sel;
		end
	end

	always_ff @(posedge clk) begin
		if (finish) begin
			y_lo      <= res_lo;
			y_hi      <= res_hi;
			dest      <= (raise || !known) ? '0 : op_dest; // tags dropped on trap
			flag_dest <= (raise || !known) ? '0 : op_flag;
			exc_code  <= raise ? code : '0;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(y_lo) && $stable(y_hi) &&
			$stable(dest) && $stable(flag_dest) && $stable(exc) && $stable(exc_code));

	// the next operation is taken only after the previous result has left
	a_single_flight: assert property (@(posedge clk) disable iff (rst)
		$rose(in_ready) |-> $past(out_valid && out_ready));

endmodule

/* verif/exec_model.svh */
// expected outputs for one operation; needs exec_pkg and expect_t in scope, shift amounts above 32 trap
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic expect_t predict(
	input logic [MODE_W-1:0]  m,
	input logic [SUB_W-1:0]   s,
	input logic [XLEN-1:0]    a,
	input logic [XLEN-1:0]    b,
	input logic [DEST_W-1:0]  d,
	input logic [FDEST_W-1:0] f
);
	expect_t e;
	logic [2*XLEN-1:0] w, za, zb, back;
	longint sa, sb;
	int unsigned n;
	logic sgn, kept;
	e    = '0;
	kept = 1'b1;
	za   = {{XLEN{1'b0}}, a};
	zb   = {{XLEN{1'b0}}, b};
	sa   = longint'($signed(a)); // sign-extended to 64 bits
	sb   = longint'($signed(b));
	n    = b;
	sgn  = (m == MODE_SARITH);
	case (m)
		MODE_UARITH, MODE_SARITH: begin
			if ((s == ARITH_DIV) && (b == '0)) begin
				e.exc  = 1'b1;
				e.code = EXC_DIV_ZERO;
			end else begin
				case (s)
					ARITH_ADD: w = sgn ? sa + sb : za + zb;
					ARITH_SUB: w = sgn ? sa - sb : za - zb;
					ARITH_MUL: w = sgn ? sa * sb : za * zb;
					default:   w = sgn ? {32'(sa % sb), 32'(sa / sb)} // truncates toward zero
						: {32'(za % zb), 32'(za / zb)};
				endcase
				{e.hi, e.lo} = w;
			end
		end
		MODE_SHIFT: begin
			if (b > 32) begin
				e.exc  = 1'b1;
				e.code = ((s == SH_LEFT) || (s == ROT_LEFT)) ? EXC_SHIFT_L : EXC_SHIFT_R;
			end else begin
				w    = za << n;        // bits leaving the top land in the high word
				back = za << (32 - n); // bits leaving the bottom, seen from the top
				case (s)
					SH_LEFT: {e.hi, e.lo} = w;
					SH_RIGHT: begin
						e.lo = a >> n;
						e.hi = back[XLEN-1:0];
					end
					ROT_LEFT: begin
						e.lo = (a << n) | (a >> (32 - n)); // rotation by definition
						e.hi = w[2*XLEN-1:XLEN];
					end
					default: begin
						e.lo = (a >> n) | back[XLEN-1:0];
						e.hi = back[XLEN-1:0];
					end
				endcase
			end
		end
		MODE_LOGIC: begin
			case (s)
				LG_AND: begin
					e.lo    = a & b;
					e.hi[0] = (a != '0) && (b != '0);
				end
				LG_OR: begin
					e.lo    = a | b;
					e.hi[0] = (a != '0) || (b != '0);
				end
				LG_NOT: begin
					e.lo    = ~b;
					e.hi[0] = (b == '0);
				end
				default: begin
					e.lo    = a ^ b;
					e.hi[0] = (a != '0) ^ (b != '0);
				end
			endcase
		end
		MODE_CMP: begin
			e.hi[0] = (a == b);
			e.hi[1] = (s == CMP_SIGNED) ? ($signed(a) < $signed(b)) :
				(s == CMP_UNSIGNED) && (a < b);
		end
		MODE_MOVE: e.lo = b;
		MODE_SEXT: e.lo = (s == SEXT_BYTE) ? {{24{b[7]}}, b[7:0]} :
			(s == SEXT_HALF) ? {{16{b[15]}}, b[15:0]} : '0;
		default: kept = 1'b0; // unknown opcode gives all zeros
	endcase
	if (!e.exc && kept) begin
		e.dest = d;
		e.flag = f;
	end
	return e;
endfunction

`endif

/* verif/exec_tb.sv */
// random operations from seed 17, checked in order against predict(); ends on a cycle limit
module exec_tb import exec_pkg::*; ();

	localparam int N_OPS        = 400;
	localparam int WORST_LAT    = 34;
	localparam int STALL_MARGIN = 20; // idle gaps and out_ready back-pressure per op
	localparam int MAX_CYCLES   = 16 + N_OPS * (WORST_LAT + STALL_MARGIN);

	typedef struct packed {
		logic [XLEN-1:0]    lo;
		logic [XLEN-1:0]    hi;
		logic [DEST_W-1:0]  dest;
		logic [FDEST_W-1:0] flag;
		logic               exc;
		logic [EXC_W-1:0]   code;
	} expect_t;

	`include "exec_model.svh"

	logic clk, rst, in_valid, in_ready, out_valid, out_ready, exc;
	logic [MODE_W-1:0] mode;
	logic [SUB_W-1:0] sub_op;
	logic [XLEN-1:0] x1, x2, y_lo, y_hi;
	logic [DEST_W-1:0] dest_sel, dest;
	logic [FDEST_W-1:0] flag_sel, flag_dest;
	logic [EXC_W-1:0] exc_code;

	expect_t exp_q[$];
	expect_t head, prev_out;
	int unsigned cycle = 0, accepted = 0, received = 0, accept_cycle = 0;
	int unsigned checks = 0, mismatches = 0, failures = 0, setup_failures = 0;
	logic fast_pending = 1'b0, hold_pending = 1'b0;

	exec_unit uut (
		.clk (clk), .rst (rst), .in_valid (in_valid), .in_ready (in_ready),
		.mode (mode), .sub_op (sub_op), .x1 (x1), .x2 (x2),
		.dest_sel (dest_sel), .flag_sel (flag_sel),
		.out_valid (out_valid), .out_ready (out_ready), .y_lo (y_lo), .y_hi (y_hi),
		.dest (dest), .flag_dest (flag_dest), .exc (exc), .exc_code (exc_code)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic expect_t sample_outputs();
		return '{y_lo, y_hi, dest, flag_dest, exc, exc_code};
	endfunction

	task automatic check_field(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] want);
		checks++;
		assert (got === want) else begin
			mismatches++;
			$display("MISMATCH %0t %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_outputs(input expect_t got, input expect_t want, input string tag);
		check_field({tag, " y_lo"}, got.lo, want.lo);
		check_field({tag, " y_hi"}, got.hi, want.hi);
		check_field({tag, " dest"}, XLEN'(got.dest), XLEN'(want.dest));
		check_field({tag, " flag_dest"}, XLEN'(got.flag), XLEN'(want.flag));
		check_field({tag, " exc"}, XLEN'(got.exc), XLEN'(want.exc));
		check_field({tag, " exc_code"}, XLEN'(got.code), XLEN'(want.code));
	endtask

	task automatic drive_random_op();
		logic [MODE_W-1:0] m;
		logic [SUB_W-1:0] s;
		logic [XLEN-1:0] a, b;
		case ($urandom_range(0, 10))
			0, 1:    m = MODE_UARITH;
			2, 3:    m = MODE_SARITH;
			4, 5:    m = MODE_SHIFT;
			6:       m = MODE_LOGIC;
			7:       m = MODE_MOVE;
			8:       m = MODE_CMP;
			9:       m = MODE_SEXT;
			default: m = ($urandom_range(0, 1) != 0) ? 5'd0 : 5'd12; // outside the kept set
		endcase
		s = SUB_W'($urandom_range(0, 3));
		if ((m == MODE_CMP) || (m == MODE_SEXT))
			s[1] = 1'b0;
		a = $urandom();
		b = $urandom();
		case ($urandom_range(0, 7))
			0: b = '0; // zero divisor, zero shift
			1: b = 32'd32;
			2: b = 32'd33;
			3: begin
				a[XLEN-1] = 1'b1;
				b[XLEN-1] = 1'b1;
			end
			4: begin
				a = 32'h8000_0000; // most negative over minus one
				b = '1;
			end
			default: if (m == MODE_SHIFT) b = XLEN'($urandom_range(0, 34));
		endcase
		in_valid <= 1'b1;
		mode     <= m;
		sub_op   <= s;
		x1       <= a;
		x2       <= b;
		dest_sel <= DEST_W'($urandom_range(0, 15));
		flag_sel <= FDEST_W'($urandom_range(0, 3));
	endtask

	always @(posedge clk)
		out_ready <= ($urandom_range(0, 3) != 0); // ready about three cycles in four

	always @(posedge clk) begin
		cycle++;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d results received", cycle, received, N_OPS);
			$display("RESULT: FAIL");
			$finish;
		end else if (!rst) begin
			if (hold_pending) begin
				checks++;
				assert (out_valid) else begin
					failures++;
					$display("%0t out_valid dropped before out_ready", $time);
				end
				check_outputs(sample_outputs(), prev_out, "held");
			end
			// out_valid rises on the edge after acceptance, seen here one edge later
			if (fast_pending && (cycle == accept_cycle + 2)) begin
				checks++;
				assert (out_valid) else begin
					failures++;
					$display("%0t single-cycle result not valid one cycle after acceptance", $time);
				end
				fast_pending = 1'b0;
			end
			if (out_valid && out_ready) begin
				assert (exp_q.size() != 0) else begin
					failures++;
					$display("%0t result delivered with no accepted operation", $time);
				end
				if (exp_q.size() != 0) begin
					head = exp_q.pop_front();
					check_outputs(sample_outputs(), head, "result");
				end
				received++;
			end
			if (in_valid && in_ready) begin
				head = predict(mode, sub_op, x1, x2, dest_sel, flag_sel);
				exp_q.push_back(head);
				accepted++;
				accept_cycle = cycle;
				fast_pending = !(((mode == MODE_UARITH) || (mode == MODE_SARITH)) && !head.exc);
			end
			hold_pending = out_valid && !out_ready;
			prev_out = sample_outputs();
		end
	end

	initial begin
		void'($urandom(17));
		rst       = 1'b1;
		in_valid  = 1'b0;
		mode      = '0;
		sub_op    = '0;
		x1        = '0;
		x2        = '0;
		dest_sel  = '0;
		flag_sel  = '0;
		out_ready = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		assert (in_ready && !out_valid && !exc) else begin
			setup_failures++;
			$display("%0t handshake outputs not idle after reset", $time);
		end
		for (int i = 0; i < N_OPS; i++) begin
			if ($urandom_range(0, 3) == 0) begin
				in_valid <= 1'b0; // idle gap
				@(posedge clk);
			end
			drive_random_op();
			@(posedge clk);
			while (!in_ready)
				@(posedge clk);
		end
		in_valid <= 1'b0;
		while (received < N_OPS)
			@(posedge clk);
		repeat (4) @(posedge clk);
		assert ((exp_q.size() == 0) && (accepted == N_OPS) && (received == N_OPS)) else begin
			setup_failures++;
			$display("%0d accepted, %0d received, %0d results never delivered",
				accepted, received, exp_q.size());
		end
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches,
			failures + setup_failures);
		if ((mismatches == 0) && (failures == 0) && (setup_failures == 0))
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* files.f */
+incdir+verif
hdl/exec_pkg.sv
hdl/int_mul.sv
hdl/int_div.sv
hdl/int_arith.sv
hdl/exec_simple.sv
hdl/exec_unit.sv
verif/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_TEXT ?= RESULT: FAIL
PASS_TEXT ?= RESULT: PASS

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) verif/exec_model.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
